//--- logic/la_bus_pkg.sv
package la_bus_pkg;

    // Wishbone data and address width
    parameter int BUS_DW = 32;

    // One select per byte lane
    parameter int BUS_SW = BUS_DW / 8;

    // Controller sequencing. A request in ST_IDLE moves to ST_ACK for one cycle
    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_ACK  = 1'b1
    } bus_state_e;

endpackage

//--- logic/la_reg_pkg.sv
package la_reg_pkg;

    // Probe bus seen by the user project
    parameter int LA_WIDTH = 128;
    parameter int LA_WORDS = LA_WIDTH / la_bus_pkg::BUS_DW;

    // Byte offsets inside the 256-byte window
    parameter logic [7:0] OFS_DATA   = 8'h00;
    parameter logic [7:0] OFS_OENB   = 8'h10;
    parameter logic [7:0] OFS_IENA   = 8'h20;
    parameter logic [7:0] OFS_SAMPLE = 8'h30;

    typedef enum logic [2:0] {
        OP_NONE     = 3'd0,
        OP_DATA     = 3'd1,
        OP_OENB     = 3'd2,
        OP_IENA     = 3'd3,
        OP_SAMPLE   = 3'd4,
        OP_UNMAPPED = 3'd5
    } reg_op_e;

    // Replace the strobed bytes of a register word
    function automatic logic [la_bus_pkg::BUS_DW-1:0] merge_bytes(
        input logic [la_bus_pkg::BUS_DW-1:0] old_word,
        input logic [la_bus_pkg::BUS_DW-1:0] new_word,
        input logic [la_bus_pkg::BUS_SW-1:0] strb
    );
        logic [la_bus_pkg::BUS_DW-1:0] merged;
        merged = old_word;
        for (int b = 0; b < la_bus_pkg::BUS_SW; b++) begin
            if (strb[b]) begin
                merged[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return merged;
    endfunction

endpackage

//--- logic/la_bus_ctrl.sv
`timescale 1ns/1ns

module la_bus_ctrl #(
    parameter logic [la_bus_pkg::BUS_DW-1:0] BASE_ADR = 32'h2200_0000
) (
    input  logic                            clk,
    input  logic                            resetn,
    input  logic [la_bus_pkg::BUS_DW-1:0]   wb_adr_i,
    input  logic [la_bus_pkg::BUS_SW-1:0]   wb_sel_i,
    input  logic                            wb_cyc_i,
    input  logic                            wb_stb_i,
    input  logic                            wb_we_i,
    output logic                            wb_ack_o,
    output la_reg_pkg::reg_op_e             op_o,
    output logic [1:0]                      word_o,
    output logic [la_bus_pkg::BUS_SW-1:0]   wstrb_o
);

    la_bus_pkg::bus_state_e state_q;
    logic                   req;
    logic [7:0]             ofs;

    assign ofs = wb_adr_i[7:0];

    // Only the upper 24 address bits select the window
    assign req = wb_cyc_i && wb_stb_i && (state_q == la_bus_pkg::ST_IDLE) &&
                 (wb_adr_i[la_bus_pkg::BUS_DW-1:8] == BASE_ADR[la_bus_pkg::BUS_DW-1:8]);

    assign word_o  = ofs[3:2];
    assign wstrb_o = wb_sel_i & {la_bus_pkg::BUS_SW{wb_we_i}};

    always_comb begin
        op_o = la_reg_pkg::OP_NONE;
        if (req) begin
            if (ofs[1:0] != 2'b00) begin
                op_o = la_reg_pkg::OP_UNMAPPED;
            end else if (ofs[7:4] == la_reg_pkg::OFS_DATA[7:4]) begin
                op_o = la_reg_pkg::OP_DATA;
            end else if (ofs[7:4] == la_reg_pkg::OFS_OENB[7:4]) begin
                op_o = la_reg_pkg::OP_OENB;
            end else if (ofs[7:4] == la_reg_pkg::OFS_IENA[7:4]) begin
                op_o = la_reg_pkg::OP_IENA;
            end else if (ofs == la_reg_pkg::OFS_SAMPLE) begin
                op_o = la_reg_pkg::OP_SAMPLE;
            end else begin
                // Inside the window but no register behind it
                op_o = la_reg_pkg::OP_UNMAPPED;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q  <= la_bus_pkg::ST_IDLE;
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= req;
            case (state_q)
                la_bus_pkg::ST_IDLE: begin
                    if (req) begin
                        state_q <= la_bus_pkg::ST_ACK;
                    end
                end
                // One acknowledge cycle, then a new request may be taken
                la_bus_pkg::ST_ACK: begin
                    state_q <= la_bus_pkg::ST_IDLE;
                end
                default: begin
                    state_q <= la_bus_pkg::ST_IDLE;
                end
            endcase
        end
    end

endmodule

//--- logic/la_lane_bank.sv
`timescale 1ns/1ns

module la_lane_bank #(
    parameter logic [la_reg_pkg::LA_WIDTH-1:0] RESET_VALUE = '0
) (
    input  logic                            clk,
    input  logic                            resetn,
    input  logic                            wr_en_i,
    input  logic [1:0]                      word_i,
    input  logic [la_bus_pkg::BUS_SW-1:0]   wstrb_i,
    input  logic [la_bus_pkg::BUS_DW-1:0]   wdata_i,
    output logic [la_reg_pkg::LA_WIDTH-1:0] bank_o
);

    logic [la_bus_pkg::BUS_DW-1:0] words_q [la_reg_pkg::LA_WORDS];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int w = 0; w < la_reg_pkg::LA_WORDS; w++) begin
                words_q[w] <= RESET_VALUE[w*la_bus_pkg::BUS_DW +: la_bus_pkg::BUS_DW];
            end
        end else if (wr_en_i) begin
            words_q[word_i] <= la_reg_pkg::merge_bytes(words_q[word_i], wdata_i, wstrb_i);
        end
    end

    // Word 0 sits in the low bits of the probe bus
    for (genvar w = 0; w < la_reg_pkg::LA_WORDS; w++) begin : g_view
        assign bank_o[w*la_bus_pkg::BUS_DW +: la_bus_pkg::BUS_DW] = words_q[w];
    end

endmodule

//--- logic/la_data_bank.sv
`timescale 1ns/1ns

module la_data_bank (
    input  logic                            clk,
    input  logic                            resetn,
    input  la_reg_pkg::reg_op_e             op_i,
    input  logic [1:0]                      word_i,
    input  logic [la_bus_pkg::BUS_SW-1:0]   wstrb_i,
    input  logic [la_bus_pkg::BUS_DW-1:0]   wdata_i,
    input  logic [la_reg_pkg::LA_WIDTH-1:0] la_data_in_i,
    input  logic [la_reg_pkg::LA_WIDTH-1:0] oenb_i,
    input  logic [la_reg_pkg::LA_WIDTH-1:0] iena_i,
    output logic [la_reg_pkg::LA_WIDTH-1:0] la_data_o
);

    logic [la_bus_pkg::BUS_DW-1:0]   words_q [la_reg_pkg::LA_WORDS];
    logic [la_reg_pkg::LA_WIDTH-1:0] capture;

    // Take a bit only where its output driver is off and its input is on
    assign capture = la_data_in_i & oenb_i & iena_i;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int w = 0; w < la_reg_pkg::LA_WORDS; w++) begin
                words_q[w] <= '0;
            end
        end else begin
            case (op_i)
                la_reg_pkg::OP_DATA: begin
                    words_q[word_i] <= la_reg_pkg::merge_bytes(words_q[word_i], wdata_i,
                                                               wstrb_i);
                end
                la_reg_pkg::OP_SAMPLE: begin
                    // All words load in the same cycle
                    for (int w = 0; w < la_reg_pkg::LA_WORDS; w++) begin
                        words_q[w] <= capture[w*la_bus_pkg::BUS_DW +: la_bus_pkg::BUS_DW];
                    end
                end
                default: begin
                end
            endcase
        end
    end

    for (genvar w = 0; w < la_reg_pkg::LA_WORDS; w++) begin : g_view
        assign la_data_o[w*la_bus_pkg::BUS_DW +: la_bus_pkg::BUS_DW] = words_q[w];
    end

endmodule

//--- logic/la_read_mux.sv
`timescale 1ns/1ns

module la_read_mux (
    input  logic                            clk,
    input  logic                            resetn,
    input  la_reg_pkg::reg_op_e             op_i,
    input  logic [1:0]                      word_i,
    input  logic [la_reg_pkg::LA_WIDTH-1:0] la_data_in_i,
    input  logic [la_reg_pkg::LA_WIDTH-1:0] oenb_i,
    input  logic [la_reg_pkg::LA_WIDTH-1:0] iena_i,
    output logic [la_bus_pkg::BUS_DW-1:0]   rdata_o
);

    logic [la_bus_pkg::BUS_DW-1:0] sel_word;

    // Data reads see the probe inputs, not the output register
    always_comb begin
        case (op_i)
            la_reg_pkg::OP_DATA: sel_word = la_data_in_i[word_i*la_bus_pkg::BUS_DW +:
                                                         la_bus_pkg::BUS_DW];
            la_reg_pkg::OP_OENB: sel_word = oenb_i[word_i*la_bus_pkg::BUS_DW +:
                                                   la_bus_pkg::BUS_DW];
            la_reg_pkg::OP_IENA: sel_word = iena_i[word_i*la_bus_pkg::BUS_DW +:
                                                   la_bus_pkg::BUS_DW];
            default:             sel_word = '0;
        endcase
    end

    // Loaded on the same edge as the bank write, so the old value is returned
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rdata_o <= '0;
        end else if (op_i != la_reg_pkg::OP_NONE) begin
            rdata_o <= sel_word;
        end
    end

endmodule

//--- logic/la_wb_top.sv
`timescale 1ns/1ns

module la_wb_top #(
    parameter logic [la_bus_pkg::BUS_DW-1:0]   BASE_ADR   = 32'h2200_0000,
    parameter logic [la_reg_pkg::LA_WIDTH-1:0] OENB_RESET = '1,
    parameter logic [la_reg_pkg::LA_WIDTH-1:0] IENA_RESET = '0
) (
    input  logic                            clk,
    input  logic                            resetn,
    input  logic [la_bus_pkg::BUS_DW-1:0]   wb_dat_i,
    input  logic [la_bus_pkg::BUS_DW-1:0]   wb_adr_i,
    input  logic [la_bus_pkg::BUS_SW-1:0]   wb_sel_i,
    input  logic                            wb_cyc_i,
    input  logic                            wb_stb_i,
    input  logic                            wb_we_i,
    output logic [la_bus_pkg::BUS_DW-1:0]   wb_dat_o,
    output logic                            wb_ack_o,
    input  logic [la_reg_pkg::LA_WIDTH-1:0] la_data_in_i,
    output logic [la_reg_pkg::LA_WIDTH-1:0] la_data_o,
    output logic [la_reg_pkg::LA_WIDTH-1:0] la_oenb_o,
    output logic [la_reg_pkg::LA_WIDTH-1:0] la_iena_o
);

    la_reg_pkg::reg_op_e           op;
    logic [1:0]                    word;
    logic [la_bus_pkg::BUS_SW-1:0] wstrb;
    logic                          oenb_wr;
    logic                          iena_wr;

    assign oenb_wr = (op == la_reg_pkg::OP_OENB);
    assign iena_wr = (op == la_reg_pkg::OP_IENA);

    la_bus_ctrl #(
        .BASE_ADR (BASE_ADR)
    ) u_bus_ctrl (
        .clk      (clk),
        .resetn   (resetn),
        .wb_adr_i (wb_adr_i),
        .wb_sel_i (wb_sel_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_ack_o (wb_ack_o),
        .op_o     (op),
        .word_o   (word),
        .wstrb_o  (wstrb)
    );

    // Active-low output enables come up with every driver off
    la_lane_bank #(
        .RESET_VALUE (OENB_RESET)
    ) u_oenb_bank (
        .clk     (clk),
        .resetn  (resetn),
        .wr_en_i (oenb_wr),
        .word_i  (word),
        .wstrb_i (wstrb),
        .wdata_i (wb_dat_i),
        .bank_o  (la_oenb_o)
    );

    la_lane_bank #(
        .RESET_VALUE (IENA_RESET)
    ) u_iena_bank (
        .clk     (clk),
        .resetn  (resetn),
        .wr_en_i (iena_wr),
        .word_i  (word),
        .wstrb_i (wstrb),
        .wdata_i (wb_dat_i),
        .bank_o  (la_iena_o)
    );

    la_data_bank u_data_bank (
        .clk          (clk),
        .resetn       (resetn),
        .op_i         (op),
        .word_i       (word),
        .wstrb_i      (wstrb),
        .wdata_i      (wb_dat_i),
        .la_data_in_i (la_data_in_i),
        .oenb_i       (la_oenb_o),
        .iena_i       (la_iena_o),
        .la_data_o    (la_data_o)
    );

    la_read_mux u_read_mux (
        .clk          (clk),
        .resetn       (resetn),
        .op_i         (op),
        .word_i       (word),
        .la_data_in_i (la_data_in_i),
        .oenb_i       (la_oenb_o),
        .iena_i       (la_iena_o),
        .rdata_o      (wb_dat_o)
    );

endmodule

//--- include/la_tb_tasks.svh
`ifndef LA_TB_TASKS_SVH
`define LA_TB_TASKS_SVH

logic [31:0] lfsr_q = 32'hd929a372;

// Reference copy of the three banks starting at their reset values
logic [la_reg_pkg::LA_WIDTH-1:0] ref_data = '0;
logic [la_reg_pkg::LA_WIDTH-1:0] ref_oenb = '1;
logic [la_reg_pkg::LA_WIDTH-1:0] ref_iena = '0;

// Galois LFSR with taps 32 22 2 1 and one step per bit returned
function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
        val    = {val[30:0], lfsr_q[0]};
        lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    end
    return val;
endfunction

function automatic logic [31:0] ref_read(input logic [7:0] ofs,
                                         input logic [la_reg_pkg::LA_WIDTH-1:0] probe);
    int base;
    base = ofs[3:2] * 32;
    if (ofs[1:0] != 2'b00) return '0;
    case (ofs[7:4])
        la_reg_pkg::OFS_DATA[7:4]: return probe[base +: 32];
        la_reg_pkg::OFS_OENB[7:4]: return ref_oenb[base +: 32];
        la_reg_pkg::OFS_IENA[7:4]: return ref_iena[base +: 32];
        default:                   return '0;
    endcase
endfunction

function automatic void ref_write(input logic [7:0] ofs, input logic [3:0] strb,
                                  input logic [31:0] wdata,
                                  input logic [la_reg_pkg::LA_WIDTH-1:0] probe);
    int base;
    base = ofs[3:2] * 32;
    if (ofs[1:0] != 2'b00) return;
    if (ofs == la_reg_pkg::OFS_SAMPLE) begin
        ref_data = probe & ref_oenb & ref_iena;
        return;
    end
    for (int b = 0; b < 4; b++) begin
        if (strb[b]) begin
            case (ofs[7:4])
                la_reg_pkg::OFS_DATA[7:4]: ref_data[base + 8*b +: 8] = wdata[8*b +: 8];
                la_reg_pkg::OFS_OENB[7:4]: ref_oenb[base + 8*b +: 8] = wdata[8*b +: 8];
                la_reg_pkg::OFS_IENA[7:4]: ref_iena[base + 8*b +: 8] = wdata[8*b +: 8];
                default: ;
            endcase
        end
    end
endfunction

// Holds the strobe until an acknowledge or until limit cycles have passed
task automatic wb_access(input logic [31:0] adr, input logic we, input logic [3:0] sel,
                         input logic [31:0] wdata, input int limit,
                         output logic [31:0] rdata, output logic acked);
    int n;
    n        = 0;
    acked    = 1'b0;
    rdata    = '0;
    wb_adr_i = adr;
    wb_we_i  = we;
    wb_sel_i = sel;
    wb_dat_i = wdata;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    while (!acked && n < limit) begin
        @(posedge clk);
        #10;
        n++;
        acked = wb_ack_o;
    end
    if (acked) rdata = wb_dat_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
endtask

`endif

//--- verif/la_wb_tb.sv
`timescale 1ns/1ns

module la_wb_tb;

    localparam logic [31:0] BASE_ADR = 32'h2200_0000;

    logic         clk;
    logic         resetn;
    logic [31:0]  wb_dat_i;
    logic [31:0]  wb_adr_i;
    logic [3:0]   wb_sel_i;
    logic         wb_cyc_i;
    logic         wb_stb_i;
    logic         wb_we_i;
    logic [31:0]  wb_dat_o;
    logic         wb_ack_o;
    logic [127:0] la_data_in_i;
    logic [127:0] la_data_o;
    logic [127:0] la_oenb_o;
    logic [127:0] la_iena_o;

    int   errors   = 0;
    int   timeouts = 0;
    logic exp_busy;
    logic req_seen;

    `include "la_tb_tasks.svh"

    la_wb_top i_dut (
        .clk          (clk),
        .resetn       (resetn),
        .wb_dat_i     (wb_dat_i),
        .wb_adr_i     (wb_adr_i),
        .wb_sel_i     (wb_sel_i),
        .wb_cyc_i     (wb_cyc_i),
        .wb_stb_i     (wb_stb_i),
        .wb_we_i      (wb_we_i),
        .wb_dat_o     (wb_dat_o),
        .wb_ack_o     (wb_ack_o),
        .la_data_in_i (la_data_in_i),
        .la_data_o    (la_data_o),
        .la_oenb_o    (la_oenb_o),
        .la_iena_o    (la_iena_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // A request is taken only when no acknowledge cycle is pending
    assign req_seen = wb_cyc_i && wb_stb_i && !exp_busy && (wb_adr_i[31:8] == BASE_ADR[31:8]);

    always @(posedge clk) begin
        if (!resetn) begin
            exp_busy <= 1'b0;
        end else begin
            exp_busy <= req_seen;
        end
    end

    ack_follows_req: assert property (@(posedge clk) disable iff (!resetn) req_seen |=> wb_ack_o)
        else begin
            errors++;
            $display("Error at %0t: wb_ack_o expected 1, got 0", $time);
        end
    ack_one_cycle: assert property (@(posedge clk) disable iff (!resetn) wb_ack_o |=> !wb_ack_o)
        else begin
            errors++;
            $display("Error at %0t: wb_ack_o expected 0, got 1", $time);
        end
    no_stray_ack: assert property (@(posedge clk) disable iff (!resetn) !req_seen |=> !wb_ack_o)
        else begin
            errors++;
            $display("Error at %0t: wb_ack_o expected 0, got 1", $time);
        end

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_banks();
        check_value("la_data_o", ref_data, la_data_o);
        check_value("la_oenb_o", ref_oenb, la_oenb_o);
        check_value("la_iena_o", ref_iena, la_iena_o);
    endtask

    task automatic reg_access(input logic [7:0] ofs, input logic we, input logic [3:0] sel,
                              input logic [31:0] wdata);
        logic [31:0] expected;
        logic [31:0] rdata;
        logic        acked;
        expected = ref_read(ofs, la_data_in_i);
        wb_access(BASE_ADR | {24'h0, ofs}, we, sel, wdata, 16, rdata, acked);
        if (!acked) begin
            timeouts++;
            $display("Timeout: no acknowledge for offset %h within 16 cycles", ofs);
        end else begin
            check_value("wb_dat_o", {96'h0, expected}, {96'h0, rdata});
            if (we) begin
                ref_write(ofs, sel, wdata, la_data_in_i);
            end
        end
        check_banks();
    endtask

    task automatic wait_ack(input int limit, output logic got, output int cycles);
        got    = 1'b0;
        cycles = 0;
        while (!got && cycles < limit) begin
            @(posedge clk);
            #10;
            cycles++;
            got = wb_ack_o;
        end
    endtask

    task automatic random_write(input logic [7:0] ofs);
        logic [31:0] sel;
        logic [31:0] wdata;
        sel   = lfsr_bits(4);
        wdata = lfsr_bits(32);
        reg_access(ofs, 1'b1, sel[3:0], wdata);
    endtask

    // Stops a run that outlasts every access sequence by far
    initial begin
        #1000000;
        $display("Simulation ran past its time limit");
        $display("Finished with errors");
        $finish;
    end

    initial begin
        logic [31:0] rdata;
        logic        acked;
        logic        got;
        int          gap;
        resetn       = 1'b0;
        wb_dat_i     = '0;
        wb_adr_i     = '0;
        wb_sel_i     = '0;
        wb_cyc_i     = 1'b0;
        wb_stb_i     = 1'b0;
        wb_we_i      = 1'b0;
        la_data_in_i = '0;
        repeat (4) @(posedge clk);
        #10;
        resetn = 1'b1;
        @(posedge clk);
        #10;
        check_banks();
        check_value("wb_ack_o", 128'h0, {127'h0, wb_ack_o});
        check_value("wb_dat_o", 128'h0, {96'h0, wb_dat_o});

        // Write then read back each configuration word
        for (int w = 0; w < 4; w++) begin
            random_write(la_reg_pkg::OFS_OENB + 8'(4 * w));
            random_write(la_reg_pkg::OFS_IENA + 8'(4 * w));
            reg_access(la_reg_pkg::OFS_OENB + 8'(4 * w), 1'b0, 4'hf, 32'h0);
            reg_access(la_reg_pkg::OFS_IENA + 8'(4 * w), 1'b0, 4'hf, 32'h0);
        end

        // Data words read back the probe inputs and not the written value
        for (int w = 0; w < 4; w++) begin
            la_data_in_i = {lfsr_bits(32), lfsr_bits(32), lfsr_bits(32), lfsr_bits(32)};
            random_write(la_reg_pkg::OFS_DATA + 8'(4 * w));
            reg_access(la_reg_pkg::OFS_DATA + 8'(4 * w), 1'b0, 4'hf, 32'h0);
        end

        la_data_in_i = {lfsr_bits(32), lfsr_bits(32), lfsr_bits(32), lfsr_bits(32)};
        random_write(la_reg_pkg::OFS_SAMPLE);

        wb_access(32'h2300_0010, 1'b1, 4'hf, 32'h0, 8, rdata, acked);
        assert (!acked) else begin
            errors++;
            $display("An address outside the window was acknowledged");
        end
        check_banks();
        random_write(8'h34);
        reg_access(8'h38, 1'b0, 4'hf, 32'h0);

        // Strobe held through two accesses
        wb_adr_i = BASE_ADR | {24'h0, la_reg_pkg::OFS_IENA};
        wb_we_i  = 1'b0;
        wb_sel_i = 4'hf;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        for (int k = 0; k < 2; k++) begin
            wait_ack(16, got, gap);
            if (!got) begin
                timeouts++;
                $display("Timeout: no acknowledge while the strobe was held");
            end else begin
                check_value("wb_dat_o", {96'h0, ref_iena[31:0]}, {96'h0, wb_dat_o});
                if (k == 1) begin
                    check_value("ack gap", 128'(2), 128'(gap));
                end
            end
        end
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        @(posedge clk);
        #10;
        check_banks();

        $display("Check errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+include
logic/la_bus_pkg.sv
logic/la_reg_pkg.sv
logic/la_bus_ctrl.sv
logic/la_lane_bank.sv
logic/la_data_bank.sv
logic/la_read_mux.sv
logic/la_wb_top.sv
verif/la_wb_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and judge the result from the simulation log
rm -f sim.log
verilator --binary --timing --assert -f sources.f --top-module la_wb_tb -o la_wb_sim \
    > build.log 2>&1 &&
./obj_dir/la_wb_sim > sim.log 2>&1 ||
echo "Build or simulation did not complete, see build.log and sim.log"
grep -q "Finished with no errors" sim.log && echo "PASS" && exit 0 ||
{ echo "FAIL"; exit 1; }
